//--- design/clk_rst_pkg.sv
// Shared types and constants for the MAC clock and reset block, imported by its modules
`default_nettype none

package clk_rst_pkg;

    // ******************************
    // Clock domains
    // ******************************

    localparam int unsigned num_domains = 8;

    // Bit positions in the clken_req and mac_gated_clk vectors
    typedef enum logic [2:0] {
        dom_pi,
        dom_pi_tx,
        dom_pi_rx,
        dom_core,
        dom_core_tx,
        dom_core_rx,
        dom_crypt,
        dom_wt
    } domain_idx_e;

    // ******************************
    // Register map
    // ******************************

    localparam logic       addr_gate_cfg   = 1'b0;
    localparam logic       addr_holdoff    = 1'b1;
    localparam logic [7:0] holdoff_default = 8'd4;

    // Address 0, one gating enable per domain
    typedef struct packed {
        logic [23:0]            reserved;
        logic [num_domains-1:0] gate_en;
    } gate_cfg_t;

    // Address 1, idle cycles kept after the last request
    typedef struct packed {
        logic [23:0] reserved;
        logic [7:0]  holdoff;
    } holdoff_cfg_t;

    // Same data word, decoded by address
    typedef union packed {
        gate_cfg_t    gate;
        holdoff_cfg_t hold;
    } reg_word_u;

    typedef struct packed {
        logic      write;
        logic      addr;
        reg_word_u wdata;
    } reg_req_t;

    typedef struct packed {
        reg_word_u rdata;
    } reg_rsp_t;

endpackage

`default_nettype wire

//--- design/reset_sequencer.sv
// Combines power-on and soft reset requests and releases platform then MAC reset in stages
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer (
    input  logic plf_clk,
    input  logic async_mac_rst_n,
    input  logic soft_reset_req_n,
    output logic plf_rst_n,
    output logic mac_core_rst_n
);

    logic [1:0] soft_sync;
    logic       int_rst_n;
    logic [4:0] plf_chain;
    logic [2:0] mac_chain;

    // ******************************
    // Soft reset synchronizer
    // ******************************

    // Set on power-on reset so a held-high request adds no delay
    always_ff @(posedge plf_clk or negedge async_mac_rst_n)
    begin
        if (!async_mac_rst_n)
            soft_sync <= 2'b11;
        else
            soft_sync <= {soft_sync[0], soft_reset_req_n};
    end

    assign int_rst_n = async_mac_rst_n & soft_sync[1];

    // ******************************
    // Staged release
    // ******************************

    // Platform reset, released on the fifth edge
    always_ff @(posedge plf_clk or negedge int_rst_n)
    begin
        if (!int_rst_n)
            plf_chain <= '0;
        else
            plf_chain <= {plf_chain[3:0], 1'b1};
    end

    // MAC reset follows the platform reset by three edges
    always_ff @(posedge plf_clk or negedge int_rst_n)
    begin
        if (!int_rst_n)
            mac_chain <= '0;
        else
            mac_chain <= {mac_chain[1:0], plf_chain[4]};
    end

    assign plf_rst_n      = plf_chain[4];
    assign mac_core_rst_n = mac_chain[2];

endmodule

`default_nettype wire

//--- design/gating_regs.sv
// Register port holding the per-domain gating bits and the idle hold-off count
`timescale 1ns/1ps
`default_nettype none

module gating_regs
    import clk_rst_pkg::*;
(
    input  logic       plf_clk,
    input  logic       plf_rst_n,
    input  reg_req_t   reg_req,
    input  logic       reg_req_valid,
    output logic       reg_req_ready,
    output reg_rsp_t   reg_rsp,
    output logic       reg_rsp_valid,
    input  logic       reg_rsp_ready,
    output gate_cfg_t  gate_cfg,
    output logic [7:0] holdoff
);

    logic      req_fire;
    reg_word_u rd_word;

    // One response slot, new requests wait until it is taken
    assign reg_req_ready = !reg_rsp_valid;
    assign req_fire      = reg_req_valid && reg_req_ready;

    // Read data for the addressed register
    always_comb
    begin
        rd_word = '0;
        if (reg_req.addr == addr_gate_cfg)
            rd_word.gate = gate_cfg;
        else
            rd_word.hold.holdoff = holdoff;
    end

    // ******************************
    // Configuration registers
    // ******************************

    always_ff @(posedge plf_clk or negedge plf_rst_n)
    begin
        if (!plf_rst_n)
        begin
            gate_cfg <= '{reserved: '0, gate_en: '1};
            holdoff  <= holdoff_default;
        end
        else if (req_fire && reg_req.write)
        begin
            if (reg_req.addr == addr_gate_cfg)
                gate_cfg.gate_en <= reg_req.wdata.gate.gate_en;
            else
                holdoff <= reg_req.wdata.hold.holdoff;
        end
    end

    // ******************************
    // Response channel
    // ******************************

    always_ff @(posedge plf_clk or negedge plf_rst_n)
    begin
        if (!plf_rst_n)
            reg_rsp_valid <= 1'b0;
        else if (req_fire)
            reg_rsp_valid <= 1'b1;
        else if (reg_rsp_ready)
            reg_rsp_valid <= 1'b0;
    end

    // Writes echo the word as written
    always_ff @(posedge plf_clk)
    begin
        if (req_fire)
            reg_rsp.rdata <= reg_req.write ? reg_req.wdata : rd_word;
    end

endmodule

`default_nettype wire

//--- design/clock_gating_ctrl.sv
// Per-domain idle hold-off and latch-based clock gates producing the eight MAC clocks
`timescale 1ns/1ps
`default_nettype none

module clock_gating_ctrl
    import clk_rst_pkg::*;
#(
    parameter int unsigned holdoff_width = 8
)
(
    input  logic                   plf_clk,
    input  logic                   mac_core_rst_n,
    input  logic [num_domains-1:0] clken_req,
    input  gate_cfg_t              gate_cfg,
    input  logic [7:0]             holdoff,
    output logic [num_domains-1:0] mac_gated_clk
);

    logic [holdoff_width-1:0] holdoff_lim;

    // Hold-off resized to the counter width
    assign holdoff_lim = holdoff_width'(holdoff);

    for (genvar i = 0; i < num_domains; i++)
    begin : g_dom
        logic [holdoff_width-1:0] idle_cnt;
        logic                     idle_hold;
        logic                     en_q;
        logic                     en_lat;

        assign idle_hold = (idle_cnt < holdoff_lim);

        // ******************************
        // Idle counter
        // ******************************

        // Starts saturated so nothing runs after reset without a request
        always_ff @(posedge plf_clk or negedge mac_core_rst_n)
        begin
            if (!mac_core_rst_n)
                idle_cnt <= '1;
            else if (clken_req[i])
                idle_cnt <= '0;
            else if (idle_hold)
                idle_cnt <= idle_cnt + 1'b1;
        end

        // Registered enable
        // a clear gate bit keeps the domain free running
        always_ff @(posedge plf_clk or negedge mac_core_rst_n)
        begin
            if (!mac_core_rst_n)
                en_q <= 1'b0;
            else
                en_q <= clken_req[i] | idle_hold | ~gate_cfg.gate_en[i];
        end

        // ******************************
        // Clock gate
        // ******************************

        // Transparent in the low phase so the high phase is never cut
        always_latch
        begin
            if (!plf_clk)
                en_lat = en_q;
        end

        assign mac_gated_clk[i] = plf_clk & en_lat;
    end

endmodule

`default_nettype wire

//--- design/lp_clock_switch.sv
// Glitch-free switch of mac_lp_clk between the gated core clock and the 32 kHz clock
`timescale 1ns/1ps
`default_nettype none

module lp_clock_switch (
    input  logic plf_clk,
    input  logic clk_32k,
    input  logic plf_rst_n,
    input  logic lp_clk_switch_req,
    input  logic mac_core_clk,
    output logic mac_lp_clk,
    output logic lp_clk_on_slow
);

    logic [1:0] fast_sync;
    logic [1:0] slow_sync;
    logic       fast_sel;
    logic       slow_sel;

    // ******************************
    // Fast side select
    // ******************************

    // mac_core_clk is gated from plf_clk, so its falling edge is safe here
    always_ff @(negedge plf_clk or negedge plf_rst_n)
    begin
        if (!plf_rst_n)
            fast_sync <= 2'b11;
        else
            fast_sync <= {fast_sync[0], ~lp_clk_switch_req & ~slow_sel};
    end

    assign fast_sel = fast_sync[1];

    // ******************************
    // Slow side select
    // ******************************

    // Released only once the fast side has dropped
    always_ff @(negedge clk_32k or negedge plf_rst_n)
    begin
        if (!plf_rst_n)
            slow_sync <= 2'b00;
        else
            slow_sync <= {slow_sync[0], lp_clk_switch_req & ~fast_sel};
    end

    assign slow_sel = slow_sync[1];

    // At most one select is high at any time
    assign mac_lp_clk     = (mac_core_clk & fast_sel) | (clk_32k & slow_sel);
    assign lp_clk_on_slow = slow_sel;

endmodule

`default_nettype wire

//--- design/mac_clock_reset_top.sv
// Top level of the MAC clock and reset block, connecting reset, registers, gating and LP switch
`timescale 1ns/1ps
`default_nettype none

module mac_clock_reset_top
    import clk_rst_pkg::*;
#(
    parameter int unsigned holdoff_width = 8
)
(
    input  logic                   plf_clk,
    input  logic                   clk_32k,
    input  logic                   async_mac_rst_n,
    input  logic                   soft_reset_req_n,
    input  logic [num_domains-1:0] clken_req,
    input  reg_req_t               reg_req,
    input  logic                   reg_req_valid,
    input  logic                   reg_rsp_ready,
    input  logic                   lp_clk_switch_req,
    output logic                   plf_rst_n,
    output logic                   mac_core_rst_n,
    output logic                   reg_req_ready,
    output reg_rsp_t               reg_rsp,
    output logic                   reg_rsp_valid,
    output logic [num_domains-1:0] mac_gated_clk,
    output logic                   mac_lp_clk,
    output logic                   lp_clk_on_slow
);

    gate_cfg_t  gate_cfg;
    logic [7:0] holdoff;

    reset_sequencer u_reset_sequencer (
        .plf_clk          (plf_clk),
        .async_mac_rst_n  (async_mac_rst_n),
        .soft_reset_req_n (soft_reset_req_n),
        .plf_rst_n        (plf_rst_n),
        .mac_core_rst_n   (mac_core_rst_n)
    );

    gating_regs u_gating_regs (
        .plf_clk       (plf_clk),
        .plf_rst_n     (plf_rst_n),
        .reg_req       (reg_req),
        .reg_req_valid (reg_req_valid),
        .reg_req_ready (reg_req_ready),
        .reg_rsp       (reg_rsp),
        .reg_rsp_valid (reg_rsp_valid),
        .reg_rsp_ready (reg_rsp_ready),
        .gate_cfg      (gate_cfg),
        .holdoff       (holdoff)
    );

    clock_gating_ctrl #(
        .holdoff_width (holdoff_width)
    ) u_clock_gating_ctrl (
        .plf_clk        (plf_clk),
        .mac_core_rst_n (mac_core_rst_n),
        .clken_req      (clken_req),
        .gate_cfg       (gate_cfg),
        .holdoff        (holdoff),
        .mac_gated_clk  (mac_gated_clk)
    );

    // Core domain clock is the fast source of the LP clock
    lp_clock_switch u_lp_clock_switch (
        .plf_clk           (plf_clk),
        .clk_32k           (clk_32k),
        .plf_rst_n         (plf_rst_n),
        .lp_clk_switch_req (lp_clk_switch_req),
        .mac_core_clk      (mac_gated_clk[dom_core]),
        .mac_lp_clk        (mac_lp_clk),
        .lp_clk_on_slow    (lp_clk_on_slow)
    );

endmodule

`default_nettype wire

//--- tests/clk_rst_properties.sv
// Concurrent assertions on reset order and register handshakes that are bound into the top level
`timescale 1ns/1ps
`default_nettype none

module clk_rst_properties
    import clk_rst_pkg::*;
(
    input logic     plf_clk,
    input logic     plf_rst_n,
    input logic     mac_core_rst_n,
    input reg_req_t reg_req,
    input logic     reg_req_valid,
    input logic     reg_req_ready,
    input reg_rsp_t reg_rsp,
    input logic     reg_rsp_valid,
    input logic     reg_rsp_ready
);

    int unsigned fail_cnt = 0;

    // MAC reset never released ahead of the platform reset
    rst_order: assert property (@(posedge plf_clk) plf_rst_n || !mac_core_rst_n)
        else
        begin
            fail_cnt++;
            $error("mac_core_rst_n high while plf_rst_n is low");
        end

    req_hold: assert property (@(posedge plf_clk) disable iff (!plf_rst_n)
        reg_req_valid && !reg_req_ready |=> reg_req_valid && $stable(reg_req))
        else
        begin
            fail_cnt++;
            $error("register request changed before it was accepted");
        end

    rsp_hold: assert property (@(posedge plf_clk) disable iff (!plf_rst_n)
        reg_rsp_valid && !reg_rsp_ready |=> reg_rsp_valid && $stable(reg_rsp))
        else
        begin
            fail_cnt++;
            $error("register response changed before it was taken");
        end

endmodule

bind mac_clock_reset_top clk_rst_properties u_props (.*);

`default_nettype wire

//--- tests/clk_rst_checker.sv
// Monitor in the testbench that predicts resets, responses and gated pulse counts of the DUT
`timescale 1ns/1ps
`default_nettype none

module clk_rst_checker
    import clk_rst_pkg::*;
(
    input logic                   plf_clk,
    input logic                   clk_32k,
    input logic                   async_mac_rst_n,
    input logic                   soft_reset_req_n,
    input logic [num_domains-1:0] clken_req,
    input reg_req_t               reg_req,
    input logic                   reg_req_valid,
    input logic                   reg_req_ready,
    input reg_rsp_t               reg_rsp,
    input logic                   reg_rsp_valid,
    input logic                   reg_rsp_ready,
    input logic                   plf_rst_n,
    input logic                   mac_core_rst_n,
    input logic [num_domains-1:0] mac_gated_clk,
    input logic                   mac_lp_clk,
    input logic                   lp_clk_on_slow,
    input logic                   win,
    input logic                   lp_win
);

    int unsigned                  err_cnt = 0;
    int unsigned                  cmp_err = 0;
    int unsigned                  err_base = 0;
    int                           tests_run = 0;
    int                           tests_failed = 0;
    logic [31:0]                  exp_rsp_q[$];
    logic [num_domains-1:0][31:0] act_arr;
    int unsigned                  act_base[num_domains] = '{default: 0};
    int unsigned                  exp_cnt[num_domains] = '{default: 0};
    int unsigned                  exp_base[num_domains] = '{default: 0};
    int unsigned                  since[num_domains] = '{default: 255};
    logic [num_domains-1:0]       en_prev = '0;
    logic [7:0]                   gate_sh = 8'hff;
    logic [7:0]                   hold_sh = holdoff_default;
    int unsigned                  rel = 0;
    int unsigned                  soft_cnt = 2;
    logic                         fire_pend = 1'b0;
    int unsigned                  lp_cnt = 0;
    int unsigned                  slow_cnt = 0;
    int unsigned                  core_cnt = 0;
    int unsigned                  lp_base = 0;
    int unsigned                  slow_base = 0;
    int unsigned                  core_base = 0;

    function automatic void show_mismatch(input string name, input logic [31:0] e,
                                          input logic [31:0] g);
        $display("mismatch %s: expected %h, got %h", name, e, g);
    endfunction

    // ******************************
    // Pulse counters
    // ******************************

    for (genvar g = 0; g < num_domains; g++)
    begin : g_cnt
        int unsigned pulses = 0;
        always @(posedge mac_gated_clk[g])
            if (win)
                pulses <= pulses + 1;
        assign act_arr[g] = pulses;
    end

    always @(posedge mac_lp_clk)
        if (lp_win)
            lp_cnt <= lp_cnt + 1;

    always @(posedge clk_32k)
        if (lp_win)
            slow_cnt <= slow_cnt + 1;

    always @(posedge mac_gated_clk[dom_core])
        if (lp_win)
            core_cnt <= core_cnt + 1;

    // ******************************
    // Reference model
    // ******************************

    // Inputs are stable here and equal to what the next rising edge samples
    always @(negedge plf_clk)
    begin : model
        logic        fire;
        logic        exp_plf;
        logic        exp_mac;
        logic [31:0] e;
        exp_plf = async_mac_rst_n && (rel >= 5);
        exp_mac = async_mac_rst_n && (rel >= 8);
        if (plf_rst_n !== exp_plf)
        begin
            show_mismatch("plf_rst_n", 32'(exp_plf), 32'(plf_rst_n));
            err_cnt++;
        end
        if (mac_core_rst_n !== exp_mac)
        begin
            show_mismatch("mac_core_rst_n", 32'(exp_mac), 32'(mac_core_rst_n));
            err_cnt++;
        end
        // LP clock starts on the fast side
        if (!plf_rst_n && lp_clk_on_slow !== 1'b0)
        begin
            show_mismatch("lp_clk_on_slow", 32'h0, 32'(lp_clk_on_slow));
            err_cnt++;
        end
        // Release stages count once the soft request has been high two edges
        if (async_mac_rst_n && soft_cnt >= 2)
            rel = rel + 1;
        else
            rel = 0;
        soft_cnt = soft_reset_req_n ? ((soft_cnt < 3) ? soft_cnt + 1 : soft_cnt) : 0;

        for (int i = 0; i < num_domains; i++)
        begin
            if (win)
                exp_cnt[i] = exp_cnt[i] + 32'(en_prev[i]);
            if (!mac_core_rst_n)
            begin
                since[i]   = 255;
                en_prev[i] = 1'b0;
            end
            else
            begin
                if (clken_req[i])
                    since[i] = 0;
                else if (since[i] < 255)
                    since[i] = since[i] + 1;
                en_prev[i] = (since[i] <= 32'(hold_sh)) || !gate_sh[i];
            end
        end

        fire = reg_req_valid && reg_req_ready;
        if (!plf_rst_n)
        begin
            gate_sh = 8'hff;
            hold_sh = holdoff_default;
        end
        else if (fire && reg_req.write)
        begin
            if (reg_req.addr == addr_gate_cfg)
                gate_sh = reg_req.wdata.gate.gate_en;
            else
                hold_sh = reg_req.wdata.hold.holdoff;
        end

        // Response channel
        if (fire_pend && !reg_rsp_valid)
        begin
            show_mismatch("reg_rsp_valid", 32'h1, 32'h0);
            err_cnt++;
        end
        fire_pend = fire;
        if (reg_rsp_valid && reg_req_ready)
        begin
            $display("reg_req_ready is high while a response is waiting");
            err_cnt++;
        end
        if (reg_rsp_valid && reg_rsp_ready)
        begin
            if (exp_rsp_q.size() == 0)
            begin
                $display("a response arrived with no request outstanding");
                err_cnt++;
            end
            else
            begin
                e = exp_rsp_q.pop_front();
                if (reg_rsp.rdata !== e)
                begin
                    show_mismatch("reg_rsp", e, reg_rsp.rdata);
                    err_cnt++;
                end
            end
        end
    end

    // ******************************
    // Calls from the testbench
    // ******************************

    task automatic expect_rsp(input logic [31:0] word);
        exp_rsp_q.push_back(word);
    endtask

    task automatic compare_gating();
        int unsigned got;
        int unsigned want;
        for (int i = 0; i < num_domains; i++)
        begin
            got  = act_arr[i] - act_base[i];
            want = exp_cnt[i] - exp_base[i];
            if (got != want)
            begin
                show_mismatch($sformatf("mac_gated_clk[%0d]", i), want, got);
                cmp_err++;
            end
            act_base[i] = act_arr[i];
            exp_base[i] = exp_cnt[i];
        end
    endtask

    // Slow side follows clk_32k and fast side the core domain clock
    task automatic compare_lp(input logic dir);
        int unsigned got;
        int unsigned want;
        got  = lp_cnt - lp_base;
        want = dir ? slow_cnt - slow_base : core_cnt - core_base;
        if (got != want)
        begin
            show_mismatch("mac_lp_clk", want, got);
            cmp_err++;
        end
        if (lp_clk_on_slow !== dir)
        begin
            show_mismatch("lp_clk_on_slow", 32'(dir), 32'(lp_clk_on_slow));
            cmp_err++;
        end
        lp_base   = lp_cnt;
        slow_base = slow_cnt;
        core_base = core_cnt;
    endtask

    task automatic note_failure(input string what);
        $display("%s", what);
        cmp_err++;
    endtask

    task automatic end_test(input int idx, input string name);
        int unsigned errs;
        errs = err_cnt + cmp_err - err_base;
        tests_run++;
        if (errs == 0)
            $display("test %0d %s: ok", idx, name);
        else
        begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", idx, name, errs);
        end
        err_base = err_cnt + cmp_err;
    endtask

    function automatic int unsigned error_count();
        return err_cnt + cmp_err;
    endfunction

endmodule

`default_nettype wire

//--- tests/clk_rst_tb.sv
// Testbench top for the MAC clock and reset block that runs tests/clk_rst_cases.txt against the DUT
`timescale 1ns/1ps
`default_nettype none

module clk_rst_tb
    import clk_rst_pkg::*;
();

    logic                   plf_clk;
    logic                   clk_32k;
    logic                   async_mac_rst_n;
    logic                   soft_reset_req_n;
    logic [num_domains-1:0] clken_req;
    reg_req_t               reg_req;
    logic                   reg_req_valid;
    logic                   reg_rsp_ready;
    logic                   lp_clk_switch_req;
    logic                   plf_rst_n;
    logic                   mac_core_rst_n;
    logic                   reg_req_ready;
    reg_rsp_t               reg_rsp;
    logic                   reg_rsp_valid;
    logic [num_domains-1:0] mac_gated_clk;
    logic                   mac_lp_clk;
    logic                   lp_clk_on_slow;
    logic                   win;
    logic                   lp_win;
    integer                 seed;
    int unsigned            cycles;
    int unsigned            limit;
    logic [63:0]            case_op[$];
    logic [31:0]            case_a[$];
    logic [31:0]            case_b[$];
    logic [31:0]            case_c[$];
    logic [31:0]            case_d[$];

    mac_clock_reset_top #(.holdoff_width(8)) dut (.*);

    clk_rst_checker chk (.*);

    // ******************************
    // Clocks and timeout
    // ******************************

    initial
    begin
        plf_clk = 1'b0;
        forever #20 plf_clk = ~plf_clk;
    end

    // Offset so slow edges never meet plf_clk edges
    initial
    begin
        clk_32k = 1'b0;
        #5;
        forever #150 clk_32k = ~clk_32k;
    end

    initial
    begin
        cycles = 0;
        while (cycles <= limit)
        begin
            @(posedge plf_clk);
            cycles = cycles + 1;
        end
        $display("timeout: run exceeded %0d cycles", limit);
        $display("** FAIL **");
        $finish;
    end

    // ******************************
    // Operations
    // ******************************

    function automatic int unsigned case_length(input logic [63:0] op, input logic [31:0] b,
                                                input logic [31:0] c);
        if (op == "act" || op == "rnd")
            return b + c + 4;
        else if (op == "wr" || op == "rd")
            return c + 12;
        else if (op == "lp")
            return b + 200;
        return 30;
    endfunction

    task automatic power_reset();
        @(posedge plf_clk);
        async_mac_rst_n <= 1'b0;
        repeat (3) @(posedge plf_clk);
        async_mac_rst_n <= 1'b1;
        do @(negedge plf_clk); while (!mac_core_rst_n);
    endtask

    task automatic soft_reset();
        @(posedge plf_clk);
        soft_reset_req_n <= 1'b0;
        @(posedge plf_clk);
        soft_reset_req_n <= 1'b1;
        do @(negedge plf_clk); while (plf_rst_n);
        do @(negedge plf_clk); while (!mac_core_rst_n);
    endtask

    task automatic reg_access(input logic write, input logic addr, input logic [31:0] data,
                              input int unsigned hold, input logic [31:0] expected);
        reg_req_t req;
        req.write = write;
        req.addr  = addr;
        req.wdata = data;
        chk.expect_rsp(expected);
        // Under back-pressure the same request is sent again and waits for the slot
        if (hold != 0)
            chk.expect_rsp(expected);
        @(posedge plf_clk);
        reg_req       <= req;
        reg_req_valid <= 1'b1;
        reg_rsp_ready <= (hold == 0);
        do @(negedge plf_clk); while (!reg_req_ready);
        @(posedge plf_clk);
        if (hold != 0)
        begin
            repeat (hold) @(posedge plf_clk);
            reg_rsp_ready <= 1'b1;
            do @(negedge plf_clk); while (!reg_req_ready);
            @(posedge plf_clk);
        end
        reg_req_valid <= 1'b0;
        do @(negedge plf_clk); while (!(reg_rsp_valid && reg_rsp_ready));
        @(posedge plf_clk);
    endtask

    task automatic run_activity(input logic [7:0] pattern, input int unsigned len,
                                input int unsigned tail, input logic use_random);
        logic [31:0] rnd;
        @(posedge plf_clk);
        win <= 1'b1;
        repeat (len)
        begin
            rnd = $random(seed);
            clken_req <= use_random ? rnd[7:0] : pattern;
            @(posedge plf_clk);
        end
        clken_req <= '0;
        repeat (tail) @(posedge plf_clk);
        win <= 1'b0;
        @(negedge plf_clk);
        chk.compare_gating();
    endtask

    task automatic lp_switch(input logic dir, input int unsigned window);
        @(posedge plf_clk);
        lp_clk_switch_req <= dir;
        do @(negedge plf_clk); while (lp_clk_on_slow != dir);
        // Fast select needs a few plf_clk edges after the slow side lets go
        repeat (4) @(posedge plf_clk);
        lp_win <= 1'b1;
        repeat (window) @(posedge plf_clk);
        lp_win <= 1'b0;
        @(negedge plf_clk);
        chk.compare_lp(dir);
    endtask

    // ******************************
    // Main sequence
    // ******************************

    initial
    begin : main
        int          fd;
        int          n;
        string       line;
        logic [63:0] op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        async_mac_rst_n   = 1'b0;
        soft_reset_req_n  = 1'b1;
        clken_req         = '0;
        reg_req           = '0;
        reg_req_valid     = 1'b0;
        reg_rsp_ready     = 1'b1;
        lp_clk_switch_req = 1'b0;
        win               = 1'b0;
        lp_win            = 1'b0;
        seed              = 32'h86c5;
        limit             = 200;
        fd = $fopen("tests/clk_rst_cases.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open tests/clk_rst_cases.txt");
            $display("** FAIL **");
            $finish;
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                void'($fgets(line, fd));
                a = '0;
                b = '0;
                c = '0;
                d = '0;
                if (line.len() > 1 && line.getc(0) != "#"
                    && $sscanf(line, "%s %h %h %h %h", op, a, b, c, d) >= 1)
                begin
                    case_op.push_back(op);
                    case_a.push_back(a);
                    case_b.push_back(b);
                    case_c.push_back(c);
                    case_d.push_back(d);
                    limit = limit + case_length(op, b, c);
                end
            end
            $fclose(fd);
            for (n = 0; n < case_op.size(); n++)
            begin
                op = case_op[n];
                if (op == "por")
                    power_reset();
                else if (op == "soft")
                    soft_reset();
                else if (op == "wr" || op == "rd")
                    reg_access(op == "wr", case_a[n][0], case_b[n], case_c[n], case_d[n]);
                else if (op == "act" || op == "rnd")
                    run_activity(case_a[n][7:0], case_b[n], case_c[n], op == "rnd");
                else if (op == "lp")
                    lp_switch(case_a[n][0], case_b[n]);
                else
                    chk.note_failure($sformatf("unknown operation in case %0d", n));
                chk.end_test(n, $sformatf("%0s", op));
            end
            $display("tests run %0d, failed %0d, errors %0d, assertion failures %0d",
                     chk.tests_run, chk.tests_failed, chk.error_count(),
                     dut.u_props.fail_cnt);
            if (chk.tests_failed == 0 && chk.error_count() == 0 && dut.u_props.fail_cnt == 0)
                $display("** PASS **");
            else
                $display("** FAIL **");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tests/clk_rst_cases.txt
# op a b c d, values in hex
# por/soft reset; wr/rd a=addr b=data c=rsp hold cycles d=expected word
# act a=request pattern b=active cycles c=idle tail; rnd random pattern; lp a=1 slow b=window
por  0 0        0 0
rd   0 0        0 000000ff
rd   1 0        0 00000004
act  0 0        14 0
wr   0 0000000f 0 0000000f
rd   0 0        3 0000000f
act  0 0        10 0
wr   0 000000ff 0 000000ff
wr   1 00000003 2 00000003
act  a5 6       8 0
act  3c 1       8 0
rnd  0 18       c 0
wr   1 00000000 0 00000000
act  ff 4       6 0
wr   0 00000000 0 00000000
lp   1 1e       0 0
lp   0 14       0 0
soft 0 0        0 0
rd   0 0        0 000000ff
rd   1 0        1 00000004

//--- build.f
design/clk_rst_pkg.sv
design/reset_sequencer.sv
design/gating_regs.sv
design/clock_gating_ctrl.sv
design/lp_clock_switch.sv
design/mac_clock_reset_top.sv
tests/clk_rst_properties.sv
tests/clk_rst_checker.sv
tests/clk_rst_tb.sv

//--- Bender.yml
package:
  name: mac_clock_reset

sources:
  - files:
      - design/clk_rst_pkg.sv
      - design/reset_sequencer.sv
      - design/gating_regs.sv
      - design/clock_gating_ctrl.sv
      - design/lp_clock_switch.sv
      - design/mac_clock_reset_top.sv
  - target: test
    files:
      - tests/clk_rst_properties.sv
      - tests/clk_rst_checker.sv
      - tests/clk_rst_tb.sv
